//--- common/obj_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite layer definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package obj_pkg;

    // Object table geometry
    localparam int obj_count = 128;
    localparam int obj_words = 8;
    localparam int tbl_aw    = 10;
    localparam int idx_w     = $clog2(obj_words);
    localparam int obj_w     = tbl_aw - idx_w;

    localparam int       line_last = 223;   // Last visible line
    localparam bit [7:0] end_mark  = 8'hf0; // Bottom byte at or above ends the table

    // Word index inside one object entry
    localparam bit [idx_w-1:0] w_pos     = 3'd0; // Bottom, top
    localparam bit [idx_w-1:0] w_xpos    = 3'd1;
    localparam bit [idx_w-1:0] w_pitch   = 3'd2;
    localparam bit [idx_w-1:0] w_offset  = 3'd3; // Flip in bit 15
    localparam bit [idx_w-1:0] w_attr    = 3'd4;
    localparam bit [idx_w-1:0] w_scratch = 3'd7; // Running row offset

    // Fields of the table words
    localparam int x_w       = 9;
    localparam int hflip_bit = 15;
    localparam int pal_lsb   = 8;
    localparam int pal_w     = 6;
    localparam int bank_lsb  = 4;
    localparam int bank_w    = 3;
    localparam int prio_lsb  = 0;
    localparam int prio_w    = 2;

    // Line buffer pixel is prio, palette, colour
    localparam int pix_w = prio_w + pal_w + 4;

    // Sprite ROM word address, bank then offset
    localparam int rom_aw = 18;
    localparam int rom_ow = rom_aw - bank_w;

    typedef enum logic [2:0] {
        st_idle,
        st_head,
        st_xpos,
        st_pitch,
        st_offset,
        st_attr,
        st_scratch,
        st_draw
    } scan_state_t;

endpackage

//--- obj/obj_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Object table RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module obj_table (
    input  logic                       clk,
    input  logic                       rst,
    // CPU side, write only
    input  logic [obj_pkg::tbl_aw-1:0] cpu_addr,
    input  logic [15:0]                cpu_din,
    input  logic                       cpu_we,
    // Scanner side
    input  logic [obj_pkg::tbl_aw-1:0] tbl_addr,
    input  logic [15:0]                tbl_din,
    input  logic                       tbl_we,
    output logic [15:0]                tbl_dout
);
    import obj_pkg::*;

    logic [15:0] mem [0:2**tbl_aw-1];

    always_ff @(posedge clk) begin
        if (tbl_we) mem[tbl_addr] <= tbl_din;
        if (cpu_we) mem[cpu_addr] <= cpu_din; // Last one wins on a clash
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tbl_dout <= '0;
        end else begin
            tbl_dout <= mem[tbl_addr];
        end
    end

endmodule

//--- obj/obj_scan.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-line object scanner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module obj_scan (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flip,
    input  logic                       hstart,
    input  logic [8:0]                 vrender,
    // Object table
    output logic [obj_pkg::tbl_aw-1:0] tbl_addr,
    output logic [15:0]                tbl_din,
    output logic                       tbl_we,
    input  logic [15:0]                tbl_dout,
    // Draw command
    output logic                       dr_start,
    input  logic                       dr_busy,
    output logic [obj_pkg::x_w-1:0]    dr_xpos,
    output logic [15:0]                dr_offset,
    output logic [obj_pkg::bank_w-1:0] dr_bank,
    output logic [obj_pkg::prio_w-1:0] dr_prio,
    output logic [obj_pkg::pal_w-1:0]  dr_pal
);
    import obj_pkg::*;

    scan_state_t       st;
    logic [obj_w-1:0]  cur_obj;
    logic [idx_w-1:0]  idx;
    logic              stall;   // Table read for the new object in flight
    logic              first;   // Line equals top
    logic [7:0]        line;
    logic [8:0]        vrf;
    logic              scan_ok;
    logic [7:0]        top;
    logic [7:0]        bottom;
    logic              inzone;
    logic              badobj;
    logic              skip;
    logic              issue;
    logic              last_obj;
    logic [x_w-1:0]    xpos;
    logic [15:0]       pitch;   // Two's complement
    logic [15:0]       offset;
    logic [15:0]       next_offset;
    logic [bank_w-1:0] bank;
    logic [prio_w-1:0] prio;
    logic [pal_w-1:0]  pal;

    assign vrf      = flip ? 9'(line_last) - vrender : vrender;
    assign scan_ok  = vrf <= 9'(line_last);
    assign tbl_addr = {cur_obj, idx};
    assign tbl_din  = offset;

    assign top      = tbl_dout[7:0];
    assign bottom   = tbl_dout[15:8];
    assign inzone   = line >= top && bottom > line;
    assign badobj   = top >= bottom;
    assign last_obj = cur_obj == obj_w'(obj_count - 1);

    assign skip  = st == st_head && !stall && bottom < end_mark && (!inzone || badobj);
    assign issue = st == st_draw && !dr_busy && !hstart;

    // First line starts from word 3, later ones from the scratch word
    assign next_offset = first ? offset : tbl_dout + pitch;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= st_idle;
            cur_obj  <= '0;
            idx      <= w_pos;
            stall    <= 1'b0;
            line     <= '0;
            tbl_we   <= 1'b0;
            dr_start <= 1'b0;
        end else begin
            tbl_we   <= 1'b0;
            dr_start <= 1'b0;
            if (hstart && (st == st_idle || st == st_draw)) begin
                // New line, a pending draw wait is dropped
                cur_obj <= '0;
                idx     <= w_pos;
                stall   <= 1'b1;
                line    <= vrf[7:0];
                st      <= scan_ok ? st_head : st_idle;
            end else begin
                case (st)
                    st_head: begin
                        if (stall) begin
                            stall <= 1'b0;
                            idx   <= w_xpos;
                        end else if (bottom >= end_mark) begin
                            st <= st_idle; // End of table
                        end else if (!skip) begin
                            idx <= w_pitch;
                            st  <= st_xpos;
                        end
                    end
                    st_xpos: begin
                        idx <= w_offset;
                        st  <= st_pitch;
                    end
                    st_pitch: begin
                        idx <= w_attr;
                        st  <= st_offset;
                    end
                    st_offset: begin
                        idx <= w_scratch;
                        st  <= st_attr;
                    end
                    st_attr:    st <= st_scratch;
                    st_scratch: begin
                        tbl_we <= 1'b1; // Lands while waiting in st_draw
                        st     <= st_draw;
                    end
                    st_draw:  dr_start <= !dr_busy;
                    default:  st <= st_idle;
                endcase
                if (skip || issue) begin
                    if (last_obj) begin
                        st <= st_idle;
                    end else begin
                        cur_obj <= cur_obj + 1'b1;
                        idx     <= w_pos;
                        stall   <= 1'b1;
                        st      <= st_head;
                    end
                end
            end
        end
    end

    // Object fields and the held command
    always_ff @(posedge clk) begin
        case (st)
            st_head:   first  <= top == line;
            st_xpos:   xpos   <= tbl_dout[x_w-1:0];
            st_pitch:  pitch  <= tbl_dout;
            st_offset: offset <= tbl_dout;
            st_attr: begin
                pal  <= tbl_dout[pal_lsb +: pal_w];
                bank <= tbl_dout[bank_lsb +: bank_w];
                prio <= tbl_dout[prio_lsb +: prio_w];
            end
            st_scratch: offset <= next_offset;
            default: ;
        endcase
        if (issue) begin
            dr_xpos   <= xpos;
            dr_offset <= offset;
            dr_bank   <= bank;
            dr_prio   <= prio;
            dr_pal    <= pal;
        end
    end

endmodule

//--- obj/obj_draw.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite draw engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module obj_draw (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       dr_start,
    output logic                       dr_busy,
    input  logic [obj_pkg::x_w-1:0]    dr_xpos,
    input  logic [15:0]                dr_offset,
    input  logic [obj_pkg::bank_w-1:0] dr_bank,
    input  logic [obj_pkg::prio_w-1:0] dr_prio,
    input  logic [obj_pkg::pal_w-1:0]  dr_pal,
    output logic [obj_pkg::rom_aw-1:0] rom_addr,
    input  logic [15:0]                rom_data,
    output logic                       buf_we,
    output logic [obj_pkg::x_w-1:0]    buf_x,
    output logic [obj_pkg::pix_w-1:0]  buf_pix
);
    import obj_pkg::*;

    typedef enum logic [1:0] {
        d_idle,
        d_fetch,
        d_pix
    } draw_state_t;

    draw_state_t       st;
    logic              first;      // ROM data valid this cycle only
    logic [15:0]       word;
    logic [15:0]       cur_word;
    logic [3:0]        pend;
    logic [3:0]        pend_cur;
    logic [3:0]        pend_left;
    logic [3:0]        opaque;
    logic [3:0]        nib [4];    // In drawing order
    logic              hit_end;
    logic [1:0]        sel;
    logic              sel_ok;
    logic              word_done;
    logic [rom_ow-1:0] addr;
    logic              hflip;
    logic [x_w-1:0]    xbase;
    logic [bank_w-1:0] bank;
    logic [prio_w-1:0] prio;
    logic [pal_w-1:0]  pal;

    assign dr_busy   = st != d_idle;
    assign rom_addr  = {bank, addr};
    assign word_done = pend_left == 4'd0;

    always_comb begin
        cur_word = first ? rom_data : word;
        hit_end  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            nib[i] = hflip ? cur_word[i*4 +: 4] : cur_word[(3-i)*4 +: 4];
            if (nib[i] == 4'hf) hit_end = 1'b1;
            opaque[i] = !hit_end && nib[i] != 4'h0; // Nothing after an end mark
        end
        pend_cur = first ? opaque : pend;
        sel      = 2'd0;
        sel_ok   = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            if (pend_cur[i]) begin
                sel    = 2'(i);
                sel_ok = 1'b1;
            end
        end
        pend_left = pend_cur & ~(4'b0001 << sel);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st     <= d_idle;
            first  <= 1'b0;
            pend   <= '0;
            buf_we <= 1'b0;
        end else begin
            buf_we <= st == d_pix && sel_ok;
            case (st)
                d_idle:  if (dr_start) st <= d_fetch;
                d_fetch: begin
                    first <= 1'b1;
                    st    <= d_pix;
                end
                d_pix: begin
                    first <= 1'b0;
                    pend  <= pend_left;
                    if (word_done) st <= hit_end ? d_idle : d_fetch;
                end
                default: st <= d_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == d_idle && dr_start) begin
            addr  <= dr_offset[rom_ow-1:0];
            hflip <= dr_offset[hflip_bit];
            xbase <= dr_xpos;
            bank  <= dr_bank;
            prio  <= dr_prio;
            pal   <= dr_pal;
        end
        if (st == d_pix) begin
            if (first) word <= rom_data;
            if (word_done && !hit_end) begin
                addr  <= hflip ? addr - 1'b1 : addr + 1'b1;
                xbase <= xbase + x_w'(4); // Wraps at 512
            end
        end
        buf_x   <= xbase + x_w'(sel);
        buf_pix <= {prio, pal, nib[sel]};
    end

endmodule

//--- obj/obj_line_buf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Double line buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module obj_line_buf (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hstart,
    // Store side
    input  logic                      buf_we,
    input  logic [obj_pkg::x_w-1:0]   buf_x,
    input  logic [obj_pkg::pix_w-1:0] buf_pix,
    // Render side
    input  logic [obj_pkg::x_w-1:0]   hdump,
    output logic [obj_pkg::pix_w-1:0] pix
);
    import obj_pkg::*;

    logic [pix_w-1:0] mem [0:2**(x_w+1)-1]; // Two halves of 512
    logic             half;                 // Half being written

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half <= 1'b0;
            pix  <= '0;
        end else begin
            if (hstart) half <= ~half;
            pix <= mem[{~half, hdump}];
        end
    end

    // Halves never overlap, so store and clear do not collide
    always_ff @(posedge clk) begin
        if (buf_we) mem[{half, buf_x}] <= buf_pix;
        mem[{~half, hdump}] <= '0; // Clear behind the read
    end

endmodule

//--- src/obj_video.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite layer top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module obj_video (
    input  logic                       clk,
    input  logic                       rst,
    // CPU table writes
    input  logic [obj_pkg::tbl_aw-1:0] cpu_addr,
    input  logic [15:0]                cpu_din,
    input  logic                       cpu_we,
    // Video timing
    input  logic                       flip,
    input  logic                       hstart,
    input  logic [8:0]                 vrender,
    input  logic [obj_pkg::x_w-1:0]    hdump,
    // Sprite ROM
    output logic [obj_pkg::rom_aw-1:0] rom_addr,
    input  logic [15:0]                rom_data,
    output logic [obj_pkg::pix_w-1:0]  pix
);
    import obj_pkg::*;

    logic [tbl_aw-1:0] tbl_addr;
    logic [15:0]       tbl_din;
    logic [15:0]       tbl_dout;
    logic              tbl_we;
    logic              dr_start;
    logic              dr_busy;
    logic [x_w-1:0]    dr_xpos;
    logic [15:0]       dr_offset;
    logic [bank_w-1:0] dr_bank;
    logic [prio_w-1:0] dr_prio;
    logic [pal_w-1:0]  dr_pal;
    logic              buf_we;
    logic [x_w-1:0]    buf_x;
    logic [pix_w-1:0]  buf_pix;

    obj_table u_table (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .tbl_addr (tbl_addr),
        .tbl_din  (tbl_din),
        .tbl_we   (tbl_we),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .flip      (flip),
        .hstart    (hstart),
        .vrender   (vrender),
        .tbl_addr  (tbl_addr),
        .tbl_din   (tbl_din),
        .tbl_we    (tbl_we),
        .tbl_dout  (tbl_dout),
        .dr_start  (dr_start),
        .dr_busy   (dr_busy),
        .dr_xpos   (dr_xpos),
        .dr_offset (dr_offset),
        .dr_bank   (dr_bank),
        .dr_prio   (dr_prio),
        .dr_pal    (dr_pal)
    );

    obj_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .dr_start  (dr_start),
        .dr_busy   (dr_busy),
        .dr_xpos   (dr_xpos),
        .dr_offset (dr_offset),
        .dr_bank   (dr_bank),
        .dr_prio   (dr_prio),
        .dr_pal    (dr_pal),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .buf_we    (buf_we),
        .buf_x     (buf_x),
        .buf_pix   (buf_pix)
    );

    obj_line_buf u_line_buf (
        .clk     (clk),
        .rst     (rst),
        .hstart  (hstart),
        .buf_we  (buf_we),
        .buf_x   (buf_x),
        .buf_pix (buf_pix),
        .hdump   (hdump),
        .pix     (pix)
    );

endmodule

//--- sim/obj_video_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel output checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module obj_video_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [obj_pkg::x_w-1:0]   hdump,
    input  logic [obj_pkg::pix_w-1:0] pix,
    output int                        n_cases,
    output int                        n_done,
    output int                        n_err
);
    import obj_pkg::*;

    localparam int max_rec = 64;

    logic [15:0]    rec [0:max_rec*4-1];
    logic [x_w-1:0] x_q     = '1;  // hdump that produced the current pix
    int             step_rd = -2;  // Line step whose pixels are read out

    task automatic compare_pixel(input int i);
        logic [pix_w-1:0] want;
        want   = rec[i*4+3][pix_w-1:0];
        n_done = n_done + 1;
        if (pix !== want) begin
            n_err = n_err + 1;
            $display("ERR case %0d step %0d x %03h: pix expected %03h actual %03h",
                     i, step_rd, x_q, want, pix);
        end else begin
            $display("case %0d step %0d x %03h: pix %03h ok", i, step_rd, x_q, pix);
        end
    endtask

    initial begin
        n_cases = 0;
        n_done  = 0;
        n_err   = 0;
        for (int i = 0; i < max_rec*4; i++) rec[i] = '0;
        $readmemh("sim/obj_cases.txt", rec);
        for (int i = 0; i < max_rec; i++) begin
            if (rec[i*4] == 16'd3) n_cases = n_cases + 1;
        end
    end

    // Sampled mid cycle, pix belongs to the hdump of the cycle before
    always @(negedge clk) begin
        if (!rst) begin
            if (x_q == '0) step_rd = step_rd + 1; // Readout of the next line begins
            for (int i = 0; i < max_rec; i++) begin
                if (rec[i*4] == 16'd3 && int'(rec[i*4+1]) == step_rd &&
                    rec[i*4+2][x_w-1:0] == x_q) begin
                    compare_pixel(i);
                end
            end
        end
        x_q = hdump;
    end

endmodule

//--- sim/obj_video_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite layer testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module obj_video_tb;
    import obj_pkg::*;

    localparam int max_rec  = 64;
    localparam int line_len = 512;

    logic              clk;
    logic              rst;
    logic [tbl_aw-1:0] cpu_addr;
    logic [15:0]       cpu_din;
    logic              cpu_we;
    logic              flip;
    logic              hstart;
    logic [8:0]        vrender;
    logic [x_w-1:0]    hdump;
    logic [rom_aw-1:0] rom_addr;
    logic [rom_aw-1:0] rom_q;    // Address seen in the last cycle
    logic [15:0]       rom_data;
    logic [pix_w-1:0]  pix;
    logic [15:0]       rec [0:max_rec*4-1];
    int                n_lines;
    int                limit  = 0;
    int                cycles = 0;
    int                n_cases;
    int                n_done;
    int                n_err;

    obj_video u_obj_video (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .flip     (flip),
        .hstart   (hstart),
        .vrender  (vrender),
        .hdump    (hdump),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .pix      (pix)
    );

    obj_video_checker u_checker (
        .clk     (clk),
        .rst     (rst),
        .hdump   (hdump),
        .pix     (pix),
        .n_cases (n_cases),
        .n_done  (n_done),
        .n_err   (n_err)
    );

    // Nibbles count up from A+1, whole word is an end mark every 8th address
    function automatic logic [15:0] rom_word(input logic [rom_aw-1:0] a);
        logic [15:0] w;
        if (a[2:0] == 3'd7) return 16'hffff;
        for (int i = 0; i < 4; i++) begin
            w[(3-i)*4 +: 4] = 4'((int'(a) + i + 1) % 15);
        end
        return w;
    endfunction

    task automatic load_table();
        for (int i = 0; i < max_rec; i++) begin
            if (rec[i*4] == 16'd1) begin
                @(posedge clk);
                #1;
                cpu_we   = 1'b1;
                cpu_addr = rec[i*4+1][tbl_aw-1:0];
                cpu_din  = rec[i*4+2];
            end
        end
        @(posedge clk);
        #1 cpu_we = 1'b0;
    endtask

    // hdump trails hstart by one cycle so x 511 is read before the swap
    task automatic run_line(input logic [8:0] v, input logic f);
        for (int c = 0; c < line_len; c++) begin
            @(posedge clk);
            #1;
            hstart  = c == 0;
            vrender = v;
            flip    = f;
            hdump   = 9'(c - 1);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) rom_q = rom_addr;

    always @(posedge clk) begin
        #1 rom_data = rom_word(rom_q); // One cycle latency
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the line sequence did not complete", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int missing;
        rst      = 1'b1;
        cpu_addr = '0;
        cpu_din  = '0;
        cpu_we   = 1'b0;
        flip     = 1'b0;
        hstart   = 1'b0;
        vrender  = '0;
        hdump    = '1;
        rom_data = '0;
        for (int i = 0; i < max_rec*4; i++) rec[i] = '0;
        $readmemh("sim/obj_cases.txt", rec);
        n_lines = 0;
        for (int i = 0; i < max_rec; i++) begin
            if (rec[i*4] == 16'd2) n_lines = n_lines + 1;
        end
        limit = (n_lines + 4) * line_len;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        load_table();
        for (int i = 0; i < max_rec; i++) begin
            if (rec[i*4] == 16'd2) run_line(rec[i*4+1][8:0], rec[i*4+2][0]);
        end
        run_line(9'h1ff, 1'b0); // Off screen, reads out the last line
        repeat (2) @(posedge clk);
        missing = n_cases - n_done;
        if (missing != 0) $display("%0d expected pixels were never sampled", missing);
        $display("Cases %0d, checked %0d, errors %0d", n_cases, n_done, n_err + missing);
        if (n_err == 0 && missing == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim/obj_cases.txt
// Columns kind a b c in hex. Kind 1 writes table word a with b, kind 2 renders line a, flip b.
// Kind 3 expects pix c at x b in the output of line step a (steps count the kind 2 records).
1 000 0d0a 0
1 001 0020 0
1 002 0008 0
1 003 0006 0
1 004 0502 0
1 008 1514 0
1 009 0040 0
1 00b 8008 0
1 00c 3f11 0
1 010 1f1e 0
1 011 0080 0
1 013 0006 0
1 014 0100 0
1 018 3228 0
1 020 1e1e 0
1 028 1f1e 0
1 029 0082 0
1 02b 000e 0
1 02c 0203 0
1 030 f000 0
1 038 1f1e 0
1 039 00a0 0
1 03b 0006 0
1 03c 0100 0
2 064 0 0
2 00a 0 0
2 00b 0 0
2 00c 0 0
2 00d 0 0
2 0cb 1 0
2 01e 0 0
3 1 020 857
3 1 021 858
3 1 023 85a
3 1 024 000
3 2 020 000
3 2 021 851
3 2 023 853
3 3 020 858
3 3 023 85b
3 4 021 000
3 4 023 000
3 5 020 000
3 5 040 7f5
3 5 041 7f4
3 5 043 7f2
3 5 044 000
3 6 080 017
3 6 082 019
3 6 083 c21
3 6 085 c23
3 6 0a0 000

//--- flist.f
common/obj_pkg.sv
obj/obj_table.sv
obj/obj_scan.sv
obj/obj_draw.sv
obj/obj_line_buf.sv
src/obj_video.sv
sim/obj_video_checker.sv
sim/obj_video_tb.sv

//--- Makefile
# Verilator build for the sprite layer

VERILATOR ?= verilator
TB_TOP    ?= obj_video_tb
RTL_TOP   ?= obj_video
FLIST     ?= flist.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
